// ==== design/core_pkg.sv ====
// core package with datapath widths, instruction encodings and the instruction word formats
package core_pkg;

    localparam int data_width     = 32;                 // register and datapath width
    localparam int reg_addr_width = 3;                  // eight registers
    localparam int imm_width      = 16;                 // imm and branch offset field
    localparam int op7_width      = 7;                  // top decode field, bits 31:25
    localparam int cond_width     = 4;                  // branch condition field
    localparam int alu_op_width   = 3;                  // same as bits 27:25
    localparam int br_kind_width  = 2;
    localparam int flag_count     = 4;                  // n z c v

    // op7 encodings, don't cares read as zero
    localparam logic [op7_width-1:0] op_mov   = 7'b0000000;
    localparam logic [op7_width-1:0] op_movt  = 7'b0000001;
    localparam logic [op7_width-1:0] op_clr   = 7'b0000010;
    localparam logic [op7_width-1:0] op_set   = 7'b0000011;
    localparam logic [op7_width-1:0] op_lsl   = 7'b0000100;
    localparam logic [op7_width-1:0] op_lsr   = 7'b0000101;
    localparam logic [op7_width-1:0] op_add   = 7'b0010001;
    localparam logic [op7_width-1:0] op_sub   = 7'b0010010;
    localparam logic [op7_width-1:0] op_and   = 7'b0010011;
    localparam logic [op7_width-1:0] op_or    = 7'b0010100;
    localparam logic [op7_width-1:0] op_xor   = 7'b0010101;
    localparam logic [op7_width-1:0] op_adds  = 7'b0011001;
    localparam logic [op7_width-1:0] op_subs  = 7'b0011010;
    localparam logic [op7_width-1:0] op_ands  = 7'b0011011;
    localparam logic [op7_width-1:0] op_ors   = 7'b0011100;
    localparam logic [op7_width-1:0] op_xors  = 7'b0011101;
    localparam logic [op7_width-1:0] op_add2  = 7'b0110001;
    localparam logic [op7_width-1:0] op_sub2  = 7'b0110010;
    localparam logic [op7_width-1:0] op_and2  = 7'b0110011;
    localparam logic [op7_width-1:0] op_or2   = 7'b0110100;
    localparam logic [op7_width-1:0] op_xor2  = 7'b0110101;
    localparam logic [op7_width-1:0] op_not   = 7'b0110110;
    localparam logic [op7_width-1:0] op_adds2 = 7'b0111001;
    localparam logic [op7_width-1:0] op_subs2 = 7'b0111010;
    localparam logic [op7_width-1:0] op_ands2 = 7'b0111011;
    localparam logic [op7_width-1:0] op_ors2  = 7'b0111100;
    localparam logic [op7_width-1:0] op_xors2 = 7'b0111101;
    localparam logic [op7_width-1:0] op_b     = 7'b1100000;
    localparam logic [op7_width-1:0] op_bcond = 7'b1100001;
    localparam logic [op7_width-1:0] op_br    = 7'b1100010;
    localparam logic [op7_width-1:0] op_nop   = 7'b1100100;
    localparam logic [op7_width-1:0] op_halt  = 7'b1101000;

    localparam logic [alu_op_width-1:0] alu_add = 3'b001;
    localparam logic [alu_op_width-1:0] alu_sub = 3'b010;
    localparam logic [alu_op_width-1:0] alu_and = 3'b011;
    localparam logic [alu_op_width-1:0] alu_or  = 3'b100;
    localparam logic [alu_op_width-1:0] alu_xor = 3'b101;
    localparam logic [alu_op_width-1:0] alu_not = 3'b110;

    // condition codes, 1100 to 1111 unassigned
    localparam logic [cond_width-1:0] cond_eq = 4'b0000;
    localparam logic [cond_width-1:0] cond_ne = 4'b0001;
    localparam logic [cond_width-1:0] cond_cs = 4'b0010;
    localparam logic [cond_width-1:0] cond_cc = 4'b0011;
    localparam logic [cond_width-1:0] cond_mi = 4'b0100;
    localparam logic [cond_width-1:0] cond_pl = 4'b0101;
    localparam logic [cond_width-1:0] cond_vs = 4'b0110;
    localparam logic [cond_width-1:0] cond_vc = 4'b0111;
    localparam logic [cond_width-1:0] cond_hi = 4'b1000;
    localparam logic [cond_width-1:0] cond_ls = 4'b1001;
    localparam logic [cond_width-1:0] cond_ge = 4'b1010;
    localparam logic [cond_width-1:0] cond_lt = 4'b1011;

    localparam int flag_n = 31;                         // flag bits inside the cpsr word
    localparam int flag_z = 30;
    localparam int flag_c = 29;
    localparam int flag_v = 28;

    localparam logic [br_kind_width-1:0] br_none   = 2'b00;
    localparam logic [br_kind_width-1:0] br_always = 2'b01;
    localparam logic [br_kind_width-1:0] br_cond   = 2'b10;
    localparam logic [br_kind_width-1:0] br_reg    = 2'b11;

    typedef struct packed {
        logic [op7_width-1:0]      op7;
        logic [reg_addr_width-1:0] dest;               // bits 24:22
        logic [reg_addr_width-1:0] op1;                // bits 21:19, also shift source
        logic [reg_addr_width-1:0] op2;                // bits 18:16
        logic [imm_width-1:0]      imm;
    } data_fmt_t;

    typedef struct packed {
        logic [op7_width-1:0]  op7;
        logic [cond_width-1:0] cond;                   // top three bits are the br pointer
        logic [data_width-op7_width-cond_width-imm_width-1:0] unused;
        logic [imm_width-1:0]  offset;                 // signed word offset
    } branch_fmt_t;

    typedef union packed {
        data_fmt_t   data;
        branch_fmt_t branch;
    } instr_word_t;

endpackage

// ==== design/instr_decoder.sv ====
// instruction decoder steering register reads, forming write data and raising enables
`timescale 1ns/1ps

module instr_decoder (
    input  logic                                instr_valid,
    input  core_pkg::instr_word_t               instr,
    input  logic [core_pkg::data_width-1:0]     rd_data1,
    input  logic [core_pkg::data_width-1:0]     rd_data2,
    input  logic [core_pkg::data_width-1:0]     result,
    output logic [core_pkg::reg_addr_width-1:0] rd_addr1,
    output logic [core_pkg::reg_addr_width-1:0] rd_addr2,
    output logic [core_pkg::reg_addr_width-1:0] wr_addr,
    output logic                                wr_en,
    output logic [core_pkg::data_width-1:0]     wr_data,
    output logic [core_pkg::alu_op_width-1:0]   alu_op,
    output logic [core_pkg::data_width-1:0]     alu_b,
    output logic                                flags_we,
    output logic [core_pkg::br_kind_width-1:0]  br_kind
);
    import core_pkg::*;

    data_fmt_t             d;                           // data view of the word
    logic [data_width-1:0] imm_ext;

    assign d       = instr.data;
    assign imm_ext = {{(data_width-imm_width){1'b0}}, d.imm};   // zero extended

    always_comb begin
        rd_addr1 = d.op1;                               // op1 and shift source share a field
        rd_addr2 = d.op2;
        wr_addr  = d.dest;
        wr_en    = 1'b0;                                // nothing retires unless decoded
        wr_data  = result;
        alu_op   = d.op7[alu_op_width-1:0];             // bits 27:25
        alu_b    = imm_ext;
        flags_we = 1'b0;
        br_kind  = br_none;
        if (instr_valid) begin
            case (d.op7)
                op_mov: begin
                    rd_addr1 = d.dest;                  // read back dest to keep upper half
                    wr_data  = {rd_data1[data_width-1:imm_width], d.imm};
                    wr_en    = 1'b1;
                end
                op_movt: begin
                    rd_addr1 = d.dest;                  // keep lower half
                    wr_data  = {d.imm, rd_data1[imm_width-1:0]};
                    wr_en    = 1'b1;
                end
                op_add, op_sub, op_and, op_or, op_xor, op_not: begin
                    wr_en = 1'b1;                       // imm form, not ignores b
                end
                op_adds, op_subs, op_ands, op_ors, op_xors: begin
                    wr_en    = 1'b1;
                    flags_we = 1'b1;
                end
                op_add2, op_sub2, op_and2, op_or2, op_xor2: begin
                    alu_b = rd_data2;                   // register form
                    wr_en = 1'b1;
                end
                op_adds2, op_subs2, op_ands2, op_ors2, op_xors2: begin
                    alu_b    = rd_data2;
                    wr_en    = 1'b1;
                    flags_we = 1'b1;
                end
                op_lsl: begin
                    wr_data = rd_data1 << d.imm;        // 32 or more shifts out everything
                    wr_en   = 1'b1;
                end
                op_lsr: begin
                    wr_data = rd_data1 >> d.imm;
                    wr_en   = 1'b1;
                end
                op_clr: begin
                    wr_data = '0;
                    wr_en   = 1'b1;
                end
                op_set: begin
                    wr_data = '1;
                    wr_en   = 1'b1;
                end
                op_b:     br_kind = br_always;
                op_bcond: br_kind = br_cond;            // condition tested in branch unit
                op_br: begin
                    rd_addr1 = instr.branch.cond[cond_width-1 -: reg_addr_width];   // pointer reg
                    br_kind  = br_reg;
                end
                op_nop, op_halt: begin
                end
                default: begin
                end
            endcase
        end
    end

    // a word is either a register write or a branch, never both
    always_comb begin
        a_wr_xor_branch: assert (!(wr_en && br_kind != br_none))
            else $error("decoder raised write and branch together");
    end

endmodule

// ==== design/alu.sv ====
// alu computing the add, sub and logic results and the next n z c v flags
`timescale 1ns/1ps

module alu (
    input  logic [core_pkg::alu_op_width-1:0] alu_op,
    input  logic [core_pkg::data_width-1:0]   a,
    input  logic [core_pkg::data_width-1:0]   b,
    input  logic [core_pkg::flag_count-1:0]   flags_in,
    output logic [core_pkg::data_width-1:0]   result,
    output logic [core_pkg::flag_count-1:0]   flags_next
);
    import core_pkg::*;

    logic [data_width:0]   sum;                         // extra bit is carry out
    logic [data_width:0]   diff;                        // extra bit is borrow
    logic [data_width-1:0] cpsr_in;
    logic [data_width-1:0] cpsr_next;

    assign sum        = {1'b0, a} + {1'b0, b};
    assign diff       = {1'b0, a} - {1'b0, b};
    assign cpsr_in    = {flags_in, {(data_width-flag_count){1'b0}}};   // flags sit at 31:28
    assign flags_next = cpsr_next[data_width-1 -: flag_count];

    always_comb begin
        cpsr_next = cpsr_in;                            // logic ops keep c and v
        case (alu_op)
            alu_add: begin
                result            = sum[data_width-1:0];
                cpsr_next[flag_c] = sum[data_width];
                cpsr_next[flag_v] = (a[data_width-1] == b[data_width-1]) &&
                                    (result[data_width-1] != a[data_width-1]);
            end
            alu_sub: begin
                result            = diff[data_width-1:0];
                cpsr_next[flag_c] = ~diff[data_width];  // no borrow when a >= b
                cpsr_next[flag_v] = (a[data_width-1] != b[data_width-1]) &&
                                    (result[data_width-1] != a[data_width-1]);
            end
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_not: result = ~a;                       // b unused
            default: result = '0;
        endcase
        cpsr_next[flag_n] = result[data_width-1];
        cpsr_next[flag_z] = (result == '0);
    end

endmodule

// ==== design/reg_file.sv ====
// register file with eight entries, two combinational reads and a registered writeback report
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [core_pkg::reg_addr_width-1:0] rd_addr1,
    input  logic [core_pkg::reg_addr_width-1:0] rd_addr2,
    input  logic                                wr_en,
    input  logic [core_pkg::reg_addr_width-1:0] wr_addr,
    input  logic [core_pkg::data_width-1:0]     wr_data,
    output logic [core_pkg::data_width-1:0]     rd_data1,
    output logic [core_pkg::data_width-1:0]     rd_data2,
    output logic                                wb_valid,
    output logic [core_pkg::reg_addr_width-1:0] wb_addr,
    output logic [core_pkg::data_width-1:0]     wb_data
);
    import core_pkg::*;

    logic [data_width-1:0] regs [2**reg_addr_width];

    assign rd_data1 = regs[rd_addr1];                   // sees every earlier commit
    assign rd_data2 = regs[rd_addr2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_width; i++) begin
                regs[i] <= '0;
            end
            wb_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                regs[wr_addr] <= wr_data;
            end
            wb_valid <= wr_en;                          // report lands with the commit
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wb_addr <= wr_addr;
            wb_data <= wr_data;
        end
    end

    a_wr_data_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_data));

endmodule

// ==== design/branch_unit.sv ====
// branch unit holding the cpsr flags, testing conditions and registering the branch target
`timescale 1ns/1ps

module branch_unit (
    input  logic                               clk,
    input  logic                               reset,
    input  core_pkg::instr_word_t              instr,
    input  logic [core_pkg::data_width-1:0]    instr_pc,
    input  logic [core_pkg::data_width-1:0]    rd_data1,
    input  logic [core_pkg::br_kind_width-1:0] br_kind,
    input  logic                               flags_we,
    input  logic [core_pkg::flag_count-1:0]    flags_next,
    output logic [core_pkg::flag_count-1:0]    flags,
    output logic                               branch_taken,
    output logic [core_pkg::data_width-1:0]    branch_target
);
    import core_pkg::*;

    branch_fmt_t           br;                          // branch view of the word
    logic [data_width-1:0] cpsr;
    logic [data_width-1:0] offset_ext;
    logic [data_width-1:0] base;
    logic                  cond_ok;
    logic                  taken;

    assign br         = instr.branch;
    assign cpsr       = {flags, {(data_width-flag_count){1'b0}}};
    assign offset_ext = {{(data_width-imm_width-2){br.offset[imm_width-1]}}, br.offset, 2'b00};
    assign base       = (br_kind == br_reg) ? rd_data1 : instr_pc;   // br uses pointer reg

    always_comb begin
        case (br.cond)                                  // flags from before this edge
            cond_eq: cond_ok = cpsr[flag_z];
            cond_ne: cond_ok = ~cpsr[flag_z];
            cond_cs: cond_ok = cpsr[flag_c];
            cond_cc: cond_ok = ~cpsr[flag_c];
            cond_mi: cond_ok = cpsr[flag_n];
            cond_pl: cond_ok = ~cpsr[flag_n];
            cond_vs: cond_ok = cpsr[flag_v];
            cond_vc: cond_ok = ~cpsr[flag_v];
            cond_hi: cond_ok = ~cpsr[flag_z] & cpsr[flag_c];
            cond_ls: cond_ok = ~(~cpsr[flag_z] & cpsr[flag_c]);
            cond_ge: cond_ok = (cpsr[flag_n] == cpsr[flag_v]);   // ge and lt compare n with v
            cond_lt: cond_ok = (cpsr[flag_n] != cpsr[flag_v]);
            default: cond_ok = 1'b0;                    // unassigned codes never taken
        endcase
    end

    always_comb begin
        case (br_kind)
            br_always, br_reg: taken = 1'b1;
            br_cond:           taken = cond_ok;
            default:           taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags        <= '0;
            branch_taken <= 1'b0;
        end else begin
            if (flags_we) begin
                flags <= flags_next;                    // only the s variants update
            end
            branch_taken <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            branch_target <= base + offset_ext;         // word offset, may be negative
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> !branch_taken);

endmodule

// ==== design/exec_core.sv ====
// single-issue execution core joining decoder, alu, register file and branch unit
`timescale 1ns/1ps

module exec_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  core_pkg::instr_word_t               instr,
    input  logic [core_pkg::data_width-1:0]     instr_pc,
    output logic                                wb_valid,
    output logic [core_pkg::reg_addr_width-1:0] wb_addr,
    output logic [core_pkg::data_width-1:0]     wb_data,
    output logic                                branch_taken,
    output logic [core_pkg::data_width-1:0]     branch_target
);
    import core_pkg::*;

    logic [reg_addr_width-1:0] rd_addr1;
    logic [reg_addr_width-1:0] rd_addr2;
    logic [reg_addr_width-1:0] wr_addr;
    logic [data_width-1:0]     rd_data1;
    logic [data_width-1:0]     rd_data2;
    logic [data_width-1:0]     wr_data;
    logic                      wr_en;
    logic [alu_op_width-1:0]   alu_op;
    logic [data_width-1:0]     alu_b;
    logic [data_width-1:0]     result;
    logic [flag_count-1:0]     flags;                   // current cpsr flags
    logic [flag_count-1:0]     flags_next;
    logic                      flags_we;
    logic [br_kind_width-1:0]  br_kind;

    instr_decoder u_decoder (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .result      (result),
        .rd_addr1    (rd_addr1),
        .rd_addr2    (rd_addr2),
        .wr_addr     (wr_addr),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .alu_op      (alu_op),
        .alu_b       (alu_b),
        .flags_we    (flags_we),
        .br_kind     (br_kind)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .a          (rd_data1),                         // operand a straight from the read port
        .b          (alu_b),
        .flags_in   (flags),
        .result     (result),
        .flags_next (flags_next)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    branch_unit u_branch_unit (
        .clk           (clk),
        .reset         (reset),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .rd_data1      (rd_data1),                      // br pointer value
        .br_kind       (br_kind),
        .flags_we      (flags_we),
        .flags_next    (flags_next),
        .flags         (flags),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

// ==== sim/tb_checks.svh ====
// testbench compare tasks for writeback, branch and idle results, with the fatal error path
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic fail_run(input string what);
    $display("%s", what);                               // the reason comes first
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_run($sformatf("CHECK FAILED t=%0t entry %0d %s got %b expected %b",
                           $time, cur_entry, name, got, exp));
    end
endtask

task automatic compare_addr(input string name,
                            input logic [core_pkg::reg_addr_width-1:0] got,
                            input logic [core_pkg::reg_addr_width-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("CHECK FAILED t=%0t entry %0d %s got %0d expected %0d",
                           $time, cur_entry, name, got, exp));
    end
endtask

task automatic compare_data(input string name,
                            input logic [core_pkg::data_width-1:0] got,
                            input logic [core_pkg::data_width-1:0] exp);
    if (got !== exp) begin
        fail_run($sformatf("CHECK FAILED t=%0t entry %0d %s got %h expected %h",
                           $time, cur_entry, name, got, exp));
    end
endtask

task automatic check_wb(input logic [core_pkg::reg_addr_width-1:0] dest,
                        input logic [core_pkg::data_width-1:0] data);
    compare_bit("wb_valid", wb_valid, 1'b1);
    compare_bit("branch_taken", branch_taken, 1'b0);    // a write is never a branch
    compare_addr("wb_addr", wb_addr, dest);
    compare_data("wb_data", wb_data, data);
endtask

task automatic check_branch(input logic [core_pkg::data_width-1:0] target);
    compare_bit("branch_taken", branch_taken, 1'b1);
    compare_bit("wb_valid", wb_valid, 1'b0);
    compare_data("branch_target", branch_target, target);
endtask

task automatic check_quiet();
    compare_bit("wb_valid", wb_valid, 1'b0);            // nothing retired
    compare_bit("branch_taken", branch_taken, 1'b0);
endtask

`endif

// ==== sim/tb_exec_core.sv ====
// testbench for the execution core, applying a stimulus table and checking each retirement
`timescale 1ns/1ps

module tb_exec_core;
    import core_pkg::*;

    localparam logic [1:0] kind_none   = 2'd0;
    localparam logic [1:0] kind_wb     = 2'd1;
    localparam logic [1:0] kind_branch = 2'd2;

    typedef struct packed {
        instr_word_t               instr;
        logic [data_width-1:0]     pc;
        logic [1:0]                kind;                // expected retirement kind
        logic [reg_addr_width-1:0] dest;
        logic [data_width-1:0]     data;
        logic [data_width-1:0]     target;
    } entry_t;

    logic                      clk;
    logic                      reset;
    logic                      instr_valid;
    instr_word_t               instr;
    logic [data_width-1:0]     instr_pc;
    logic                      wb_valid;
    logic [reg_addr_width-1:0] wb_addr;
    logic [data_width-1:0]     wb_data;
    logic                      branch_taken;
    logic [data_width-1:0]     branch_target;
    entry_t                    stim[$];
    int                        cur_entry;

    `include "tb_checks.svh"

    exec_core uut (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always #4 clk = ~clk;                               // 8 ns period

    function automatic instr_word_t enc_data(input logic [op7_width-1:0] op,
                                             input logic [reg_addr_width-1:0] dest,
                                             input logic [reg_addr_width-1:0] op1,
                                             input logic [reg_addr_width-1:0] op2,
                                             input logic [imm_width-1:0] imm);
        instr_word_t w;
        w.data.op7  = op;
        w.data.dest = dest;
        w.data.op1  = op1;
        w.data.op2  = op2;
        w.data.imm  = imm;
        return w;
    endfunction

    function automatic instr_word_t enc_branch(input logic [op7_width-1:0] op,
                                               input logic [cond_width-1:0] cond,
                                               input logic [imm_width-1:0] offset);
        instr_word_t w;
        w.branch.op7    = op;
        w.branch.cond   = cond;                         // br pointer sits in the top three bits
        w.branch.unused = '0;
        w.branch.offset = offset;
        return w;
    endfunction

    task automatic add_wb(input instr_word_t ins, input logic [reg_addr_width-1:0] dest,
                          input logic [data_width-1:0] data);
        entry_t e;
        e = '{instr: ins, pc: '0, kind: kind_wb, dest: dest, data: data, target: '0};
        stim.push_back(e);
    endtask

    task automatic add_branch(input instr_word_t ins, input logic [data_width-1:0] pc,
                              input logic [data_width-1:0] target);
        entry_t e;
        e = '{instr: ins, pc: pc, kind: kind_branch, dest: '0, data: '0, target: target};
        stim.push_back(e);
    endtask

    task automatic add_none(input instr_word_t ins, input logic [data_width-1:0] pc);
        entry_t e;
        e = '{instr: ins, pc: pc, kind: kind_none, dest: '0, data: '0, target: '0};
        stim.push_back(e);
    endtask

    task automatic build_table();
        add_wb(enc_data(op_clr, 3'd1, 3'd0, 3'd0, 16'h0005), 3'd1, 32'h0000_0000);
        add_wb(enc_data(op_set, 3'd2, 3'd0, 3'd0, 16'h0000), 3'd2, 32'hffff_ffff);
        add_wb(enc_data(op_mov, 3'd3, 3'd0, 3'd0, 16'h5678), 3'd3, 32'h0000_5678);
        add_wb(enc_data(op_movt, 3'd3, 3'd0, 3'd0, 16'h1234), 3'd3, 32'h1234_5678);
        add_wb(enc_data(op_mov, 3'd2, 3'd0, 3'd0, 16'habcd), 3'd2, 32'hffff_abcd);  // upper kept
        add_wb(enc_data(op_add, 3'd4, 3'd3, 3'd0, 16'h0100), 3'd4, 32'h1234_5778);
        add_wb(enc_data(op_sub, 3'd5, 3'd3, 3'd0, 16'h0678), 3'd5, 32'h1234_5000);
        add_wb(enc_data(op_and, 3'd6, 3'd2, 3'd0, 16'h0f0f), 3'd6, 32'h0000_0b0d);
        add_wb(enc_data(op_or, 3'd7, 3'd3, 3'd0, 16'h8001), 3'd7, 32'h1234_d679);
        add_wb(enc_data(op_xor, 3'd1, 3'd3, 3'd0, 16'hffff), 3'd1, 32'h1234_a987);
        add_wb(enc_data(op_not, 3'd1, 3'd3, 3'd0, 16'h0000), 3'd1, 32'hedcb_a987);
        add_wb(enc_data(op_add2, 3'd4, 3'd3, 3'd2, 16'h0000), 3'd4, 32'h1234_0245);
        add_wb(enc_data(op_sub2, 3'd5, 3'd3, 3'd4, 16'h0000), 3'd5, 32'h0000_5433);
        add_wb(enc_data(op_and2, 3'd6, 3'd3, 3'd2, 16'h0000), 3'd6, 32'h1234_0248);
        add_wb(enc_data(op_or2, 3'd7, 3'd5, 3'd6, 16'h0000), 3'd7, 32'h1234_567b);
        add_wb(enc_data(op_xor2, 3'd0, 3'd3, 3'd7, 16'h0000), 3'd0, 32'h0000_0003);
        add_wb(enc_data(op_lsl, 3'd4, 3'd3, 3'd0, 16'd4), 3'd4, 32'h2345_6780);
        add_wb(enc_data(op_lsr, 3'd5, 3'd3, 3'd0, 16'd4), 3'd5, 32'h0123_4567);
        add_wb(enc_data(op_lsl, 3'd6, 3'd3, 3'd0, 16'd40), 3'd6, 32'h0000_0000);
        add_wb(enc_data(op_lsr, 3'd7, 3'd3, 3'd0, 16'd40), 3'd7, 32'h0000_0000);
        // r3 - r3 leaves z and c set
        add_wb(enc_data(op_subs2, 3'd4, 3'd3, 3'd3, 16'h0000), 3'd4, 32'h0000_0000);
        add_branch(enc_branch(op_bcond, cond_eq, 16'h0008), 32'h0000_0100, 32'h0000_0120);
        add_none(enc_branch(op_bcond, cond_ne, 16'h0004), 32'h0000_0104);
        add_branch(enc_branch(op_bcond, cond_cs, 16'hfffc), 32'h0000_0108, 32'h0000_00f8);
        add_none(enc_branch(op_bcond, cond_hi, 16'h0004), 32'h0000_010c);
        add_branch(enc_branch(op_bcond, cond_ge, 16'h0001), 32'h0000_0110, 32'h0000_0114);
        add_none(enc_branch(op_bcond, cond_lt, 16'h0004), 32'h0000_0114);  // n equals v, z set
        // r2 + r2 carries out, result negative
        add_wb(enc_data(op_adds2, 3'd5, 3'd2, 3'd2, 16'h0000), 3'd5, 32'hffff_579a);
        add_branch(enc_branch(op_bcond, cond_mi, 16'h0010), 32'h0000_0200, 32'h0000_0240);
        add_none(enc_branch(op_bcond, cond_ge, 16'h0004), 32'h0000_0204);
        add_branch(enc_branch(op_bcond, cond_lt, 16'hffff), 32'h0000_0208, 32'h0000_0204);
        add_branch(enc_branch(op_bcond, cond_hi, 16'h0002), 32'h0000_020c, 32'h0000_0214);
        add_none(enc_branch(op_bcond, cond_cc, 16'h0004), 32'h0000_0210);
        // 3 + 5 clears every flag
        add_wb(enc_data(op_adds, 3'd6, 3'd0, 3'd0, 16'h0005), 3'd6, 32'h0000_0008);
        add_branch(enc_branch(op_bcond, cond_cc, 16'h0000), 32'h0000_0300, 32'h0000_0300);
        add_branch(enc_branch(op_bcond, cond_ge, 16'h7fff), 32'h0000_0304, 32'h0002_0300);
        add_none(enc_branch(op_bcond, cond_eq, 16'h0004), 32'h0000_0308);
        add_wb(enc_data(op_subs, 3'd6, 3'd6, 3'd0, 16'h0009), 3'd6, 32'hffff_ffff);  // borrow
        add_wb(enc_data(op_add, 3'd7, 3'd6, 3'd0, 16'h0001), 3'd7, 32'h0000_0000);   // no flags
        add_branch(enc_branch(op_bcond, cond_ne, 16'h0001), 32'h0000_0400, 32'h0000_0404);
        add_none(enc_branch(op_bcond, cond_cs, 16'h0004), 32'h0000_0404);
        add_branch(enc_branch(op_bcond, cond_mi, 16'hfff0), 32'h0000_0408, 32'h0000_03c8);
        add_branch(enc_branch(op_bcond, cond_lt, 16'h0003), 32'h0000_040c, 32'h0000_0418);
        add_branch(enc_branch(op_b, 4'hf, 16'h0020), 32'h0000_0500, 32'h0000_0580);
        add_branch(enc_branch(op_br, {3'd3, 1'b0}, 16'h0002), 32'h0000_0504, 32'h1234_5680);
        add_branch(enc_branch(op_br, {3'd4, 1'b0}, 16'hfffe), 32'h0000_0508, 32'hffff_fff8);
        add_none(enc_branch(op_bcond, 4'b1100, 16'h0004), 32'h0000_050c);   // unassigned cond
        add_none(enc_data(op_nop, 3'd1, 3'd3, 3'd0, 16'h00ff), 32'h0000_0600);
        add_none(enc_data(op_halt, 3'd1, 3'd3, 3'd0, 16'h00ff), 32'h0000_0604);
        add_none(enc_data(7'b0100000, 3'd1, 3'd3, 3'd0, 16'h00ff), 32'h0000_0608);
        add_none(enc_data(7'b1000000, 3'd1, 3'd3, 3'd0, 16'h00ff), 32'h0000_060c);
        add_none(enc_data(7'b1111111, 3'd1, 3'd3, 3'd0, 16'h00ff), 32'h0000_0610);
        add_wb(enc_data(op_add, 3'd0, 3'd1, 3'd0, 16'h0000), 3'd0, 32'hedcb_a987);  // r1 intact
    endtask

    task automatic wait_cycles(input int count);
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
        end
    endtask

    task automatic wait_quiet(input int limit);
        int n;
        n = 0;
        while ((wb_valid !== 1'b0 || branch_taken !== 1'b0) && n < limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (wb_valid !== 1'b0 || branch_taken !== 1'b0) begin
            fail_run("timeout: outputs did not settle to idle after reset");
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        cur_entry   = -1;                               // idle checks come before the table
        build_table();
        wait_cycles(16);
        #1;
        reset = 1'b0;
        instr = enc_data(op_set, 3'd1, 3'd0, 3'd0, 16'h0000);   // must be ignored, valid low
        wait_quiet(8);
        for (int k = 0; k < 4; k++) begin
            wait_cycles(1);
            #1;
            check_quiet();
        end
        for (int i = 0; i < stim.size(); i++) begin
            cur_entry   = i;
            instr_valid = 1'b1;
            instr       = stim[i].instr;
            instr_pc    = stim[i].pc;
            wait_cycles(1);                             // one cycle latency
            #1;
            case (stim[i].kind)
                kind_wb:     check_wb(stim[i].dest, stim[i].data);
                kind_branch: check_branch(stim[i].target);
                default:     check_quiet();
            endcase
        end
        instr_valid = 1'b0;
        wait_cycles(1);
        #1;
        check_quiet();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+sim
design/core_pkg.sv
design/instr_decoder.sv
design/alu.sv
design/reg_file.sv
design/branch_unit.sv
design/exec_core.sv
sim/tb_exec_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the execution core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_exec_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_exec_core)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "pass message not found"
exit 1
